//--- histogram_top.f
verilog/sram_pkg.sv
verilog/hist_pkg.sv
verilog/count_sram.sv
verilog/bin_clear.sv
verilog/byte_intake.sv
verilog/histogram.sv
verilog/histogram_top.sv
bench/hist_checker.sv
bench/tb_histogram.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_histogram
FILELIST  = histogram_top.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/tb_histogram.sv
`timescale 1ns/1ps

module tb_histogram;

    localparam int NUM_TESTS = 5;
    localparam int NUM_FIXED = 29;

    logic        clk;
    logic        rst;
    logic        byte_valid;
    logic [7:0]  byte_data;
    logic        byte_ready;
    logic        rd_en;
    logic [7:0]  rd_addr;
    logic [31:0] rd_data;
    logic        rd_valid;
    logic        eof;
    logic        complete;
    logic [31:0] total;
    logic [31:0] table_total;
    logic        test_done;
    int          tests_run;
    int          tests_failed;
    int          errors;

    // one row per test: offset into fixed_bytes, length, random flag, expected total
    int          test_off   [NUM_TESTS] = '{0, 1, 8, 16, 0};
    int          test_len   [NUM_TESTS] = '{1, 7, 8, 13, 65};
    bit          test_rand  [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    logic [31:0] test_total [NUM_TESTS] = '{1, 7, 8, 13, 65};

    logic [7:0] fixed_bytes [NUM_FIXED] = '{
        8'h1A,                                                  // eof only, bins stay zero
        8'h41, 8'h42, 8'h41, 8'h00, 8'hFF, 8'h41, 8'h1A,
        8'h19, 8'h1B, 8'h00, 8'hFF, 8'h80, 8'h1B, 8'h1B, 8'h1A,  // neighbours of eof
        8'h55, 8'h55, 8'h55, 8'h55, 8'h55, 8'h55,
        8'h55, 8'h55, 8'h55, 8'h55, 8'h55, 8'h55, 8'h1A
    };
    logic [7:0]  four_vals [4] = '{8'h00, 8'h41, 8'h7F, 8'hFF};
    logic [31:0] rng = 32'h5d258e0a;
    logic [7:0]  stream [$];

    histogram_top dut (.*);
    hist_checker  chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int cycle_limit();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            n += test_len[t] * 20 + 256 * 10 + 20;  // bytes, clear and readout, reset
        end
        return n;
    endfunction

    task automatic build_stream(input int t);
        stream.delete();
        for (int i = 0; i < test_len[t]; i++) begin
            if (!test_rand[t]) begin
                stream.push_back(fixed_bytes[test_off[t] + i]);
            end else if (i == test_len[t] - 1) begin
                stream.push_back(8'h1A);
            end else begin
                rng = xorshift(rng);
                stream.push_back(four_vals[rng[1:0]]);  // few values, many repeats
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        do begin
            @(negedge clk);
        end while (!byte_ready);
        @(posedge clk);
        byte_valid <= 1'b1;
        byte_data  <= b;
        @(posedge clk);
        byte_valid <= 1'b0;
    endtask

    task automatic read_bin(input logic [7:0] a);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= a;
        @(posedge clk);
        rd_en <= 1'b0;
        do begin
            @(negedge clk);
        end while (!rd_valid);
    endtask

    initial begin
        rst         = 1'b1;
        byte_valid  = 1'b0;
        byte_data   = 8'h00;
        rd_en       = 1'b0;
        rd_addr     = 8'h00;
        table_total = '0;
        test_done   = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            build_stream(t);
            @(posedge clk);
            rst         <= 1'b1;
            table_total <= test_total[t];
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            foreach (stream[i]) begin
                send_byte(stream[i]);
            end
            do begin
                @(negedge clk);
            end while (!complete);
            for (int a = 0; a < 256; a++) begin
                read_bin(8'(a));
            end
            @(posedge clk);
            test_done <= 1'b1;
            @(posedge clk);
            test_done <= 1'b0;
        end
        repeat (2) @(posedge clk);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run == NUM_TESTS) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        int limit;
        limit = cycle_limit();
        repeat (limit) @(posedge clk);
        $display("ERROR watchdog expired after %0d cycles, the DUT stopped responding", limit);
        $display("Test failed");
        $finish;
    end

endmodule

//--- bench/hist_checker.sv
`timescale 1ns/1ps

module hist_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        byte_valid,
    input  logic [7:0]  byte_data,
    input  logic        byte_ready,
    input  logic        rd_en,
    input  logic [7:0]  rd_addr,
    input  logic [31:0] rd_data,
    input  logic        rd_valid,
    input  logic        eof,
    input  logic        complete,
    input  logic [31:0] total,
    input  logic [31:0] table_total,  // expected total from the stimulus table
    input  logic        test_done,
    output int          tests_run,
    output int          tests_failed,
    output int          errors
);

    localparam logic [7:0] EOF_BYTE     = 8'h1A;
    localparam int         CLEAR_CYCLES = 256 * 3;  // one write and two busy cycles per bin

    logic [31:0] exp_bin [256];
    logic [31:0] exp_total;
    logic [7:0]  addr_q;      // bin asked for by the last host read
    int          cyc;
    int          reads;
    int          test_errs = 0;
    int          n_run     = 0;
    int          n_failed  = 0;
    int          n_errs    = 0;
    bit          eof_in;
    bit          done_seen;

    assign tests_run    = n_run;
    assign tests_failed = n_failed;
    assign errors       = n_errs;

    task automatic mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("FAIL %0t ns %s expected %0d got %0d", $time, sig, exp, act);
        test_errs++;
    endtask

    task automatic problem(input string what);
        $display("ERROR %0t ns %s", $time, what);
        test_errs++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                exp_bin[i] = '0;
            end
            exp_total = '0;
            cyc       = 0;
            reads     = 0;
            eof_in    = 1'b0;
            done_seen = 1'b0;
        end else begin
            cyc++;
            if (byte_ready && cyc <= CLEAR_CYCLES) begin
                problem("byte_ready high while bins are still being cleared");
            end
            if (eof_in && byte_ready) begin
                problem("byte_ready high again after the end-of-file byte");
            end
            if (byte_valid && byte_ready) begin
                exp_total = exp_total + 32'd1;  // eof byte counts too
                if (byte_data == EOF_BYTE) begin
                    eof_in = 1'b1;
                end else begin
                    exp_bin[byte_data] += 1;
                end
            end
            if (eof && !eof_in) begin
                problem("eof raised before the end-of-file byte arrived");
            end
            if (done_seen) begin
                if (!complete || !eof) begin
                    problem("complete or eof dropped after end of file");
                end
            end else if (complete) begin
                done_seen = 1'b1;
                if (!eof) begin
                    problem("complete rose without eof");
                end
                if (total !== exp_total) mismatch("total", exp_total, total);
                if (total !== table_total) mismatch("total", table_total, total);
            end
            if (rd_valid) begin
                if (rd_data !== exp_bin[addr_q]) begin
                    mismatch($sformatf("rd_data[%0d]", addr_q), exp_bin[addr_q], rd_data);
                end
                reads++;
            end
            if (rd_en) begin
                addr_q = rd_addr;
            end
            if (test_done) begin
                if (reads != 256) problem($sformatf("%0d of 256 bins were read back", reads));
                if (test_errs == 0) begin
                    $display("test %0d: %0d bytes, ok", n_run, exp_total);
                end else begin
                    $display("test %0d: %0d bytes, %0d errors", n_run, exp_total, test_errs);
                    n_failed++;
                end
                n_run++;
                n_errs += test_errs;
                test_errs = 0;
            end
        end
    end

endmodule

//--- verilog/histogram_top.sv
`timescale 1ns/1ps

module histogram_top
    import sram_pkg::*;
    import hist_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        byte_valid,
    input  logic [7:0]                  byte_data,
    output logic                        byte_ready,
    input  logic                        rd_en,
    input  logic [$clog2(NUM_BINS)-1:0] rd_addr,
    output logic [SRAM_DW-1:0]          rd_data,
    output logic                        rd_valid,
    output logic                        eof,
    output logic                        complete,
    output logic [SRAM_DW-1:0]          total
);

    // who owns the sram port
    typedef enum logic [1:0] {
        PH_CLEAR,
        PH_COUNT,
        PH_READOUT
    } phase_t;

    phase_t                              phase;
    sram_req_t                           clear_req;
    sram_req_t                           hist_req;
    sram_req_t                           host_req;
    sram_req_t                           sram_req;
    logic                                busy;
    logic [SRAM_DW-1:0]                  rdata;
    logic                                clear_done;
    logic                                pending;
    logic [7:0]                          held_byte;
    logic                                confirm;
    logic [$clog2(SRAM_LATENCY+2)-1:0]   rd_cnt;  // cycles until rd_valid

    assign phase = !clear_done ? PH_CLEAR : (complete ? PH_READOUT : PH_COUNT);

    always_comb begin
        host_req.op    = SRAM_NOP;
        host_req.addr  = rd_addr;
        host_req.wdata = '0;
        if (rd_en && !busy) begin
            host_req.op = SRAM_READ;
        end
    end

    always_comb begin
        case (phase)
            PH_CLEAR: sram_req = clear_req;
            PH_COUNT: sram_req = hist_req;
            default:  sram_req = host_req;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd_cnt <= '0;
        end else if (phase == PH_READOUT && host_req.op == SRAM_READ) begin
            rd_cnt <= $bits(rd_cnt)'(SRAM_LATENCY + 1);
        end else if (rd_cnt != '0) begin
            rd_cnt <= rd_cnt - 1'b1;
        end
    end

    assign rd_valid = (rd_cnt == 1);
    assign rd_data  = rdata;  // sram holds it after the read

    count_sram u_sram (
        .clk   (clk),
        .rst   (rst),
        .req   (sram_req),
        .busy  (busy),
        .rdata (rdata)
    );

    bin_clear u_clear (
        .clk        (clk),
        .rst        (rst),
        .busy       (busy),
        .req        (clear_req),
        .clear_done (clear_done)
    );

    byte_intake u_intake (
        .clk        (clk),
        .rst        (rst),
        .enable     (clear_done),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .confirm    (confirm),
        .byte_ready (byte_ready),
        .pending    (pending),
        .held_byte  (held_byte)
    );

    histogram u_hist (
        .clk       (clk),
        .rst       (rst),
        .pending   (pending),
        .held_byte (held_byte),
        .busy      (busy),
        .rdata     (rdata),
        .req       (hist_req),
        .confirm   (confirm),
        .eof       (eof),
        .complete  (complete),
        .total     (total)
    );

endmodule

//--- verilog/histogram.sv
`timescale 1ns/1ps

module histogram
    import sram_pkg::*;
    import hist_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               pending,
    input  logic [7:0]         held_byte,
    input  logic               busy,
    input  logic [SRAM_DW-1:0] rdata,
    output sram_req_t          req,
    output logic               confirm,
    output logic               eof,
    output logic               complete,
    output logic [SRAM_DW-1:0] total
);

    hist_state_t        state;
    hist_state_t        state_n;
    logic               confirm_n;
    logic               eof_n;
    logic               complete_n;
    logic [SRAM_DW-1:0] total_n;
    logic [SRAM_AW-1:0] addr;     // bin of the byte being counted
    logic [SRAM_DW-1:0] bin_val;  // incremented count to write back

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            confirm  <= 1'b0;
            eof      <= 1'b0;
            complete <= 1'b0;
            total    <= '0;
        end else begin
            state    <= state_n;
            confirm  <= confirm_n;
            eof      <= eof_n;
            complete <= complete_n;
            total    <= total_n;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && pending) begin
            addr <= held_byte;
        end
        if (state == READ_WAIT && !busy) begin
            bin_val <= rdata + 1'b1;
        end
    end

    always_comb begin
        state_n    = state;
        confirm_n  = 1'b0;
        eof_n      = eof;
        complete_n = complete;
        total_n    = total;
        req.op     = SRAM_NOP;
        req.addr   = addr;
        req.wdata  = bin_val;

        case (state)
            IDLE: begin
                if (pending) begin
                    confirm_n = 1'b1;
                    if (held_byte == EOF_CODE) begin
                        eof_n   = 1'b1;
                        state_n = HALT;
                    end else begin
                        state_n = WAIT_BUSY;
                    end
                end
            end
            WAIT_BUSY: begin
                if (!busy) begin
                    state_n = READ_REQ;
                end
            end
            READ_REQ: begin
                if (!busy) begin
                    req.op  = SRAM_READ;
                    state_n = READ_WAIT;
                end
            end
            READ_WAIT: begin
                // rdata is good on the first idle cycle
                if (!busy) begin
                    state_n = WRITE_REQ;
                end
            end
            WRITE_REQ: begin
                if (!busy) begin
                    req.op  = SRAM_WRITE;
                    total_n = total + 1'b1;
                    state_n = WRITE_WAIT;
                end
            end
            WRITE_WAIT: begin
                if (!busy) begin
                    state_n = IDLE;
                end
            end
            HALT: begin
                total_n    = total + 1'b1;  // the eof byte itself
                complete_n = 1'b1;
                state_n    = DONE;
            end
            DONE: begin
                state_n = DONE;  // parked until reset
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    // one confirm per accepted byte
    a_confirm_single: assert property (
        @(posedge clk) disable iff (rst)
        confirm |=> !confirm
    );

endmodule

//--- verilog/byte_intake.sv
`timescale 1ns/1ps

module byte_intake
    import hist_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,      // bins cleared
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       confirm,
    output logic       byte_ready,
    output logic       pending,
    output logic [7:0] held_byte
);

    logic eof_seen;  // no more input once the marker is in
    logic take;

    assign byte_ready = enable && !pending && !eof_seen;
    assign take       = byte_valid && byte_ready;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pending  <= 1'b0;
            eof_seen <= 1'b0;
        end else begin
            if (take) begin
                pending <= 1'b1;
                if (byte_data == EOF_CODE) begin
                    eof_seen <= 1'b1;
                end
            end else if (confirm) begin
                pending <= 1'b0;  // ready comes back next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_byte <= byte_data;
        end
    end

    // source has to honour the ready level
    a_valid_needs_ready: assert property (
        @(posedge clk) disable iff (rst)
        byte_valid |-> byte_ready
    );

endmodule

//--- verilog/bin_clear.sv
`timescale 1ns/1ps

module bin_clear
    import sram_pkg::*;
    import hist_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      busy,
    output sram_req_t req,
    output logic      clear_done
);

    logic [SRAM_AW-1:0] addr;       // next bin to zero
    logic               last_sent;  // final write has gone out
    logic               issue;

    assign issue = !last_sent && !busy;

    // one zero write per free slot
    always_comb begin
        req.op    = SRAM_NOP;
        req.addr  = addr;
        req.wdata = '0;
        if (issue) begin
            req.op = SRAM_WRITE;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            addr       <= '0;
            last_sent  <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            if (issue) begin
                addr <= addr + 1'b1;
                if (addr == SRAM_AW'(NUM_BINS - 1)) begin
                    last_sent <= 1'b1;
                end
            end
            // wait for the last write to leave the sram
            if (last_sent && !busy) begin
                clear_done <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/count_sram.sv
`timescale 1ns/1ps

module count_sram
    import sram_pkg::*;
    import hist_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  sram_req_t          req,
    output logic               busy,
    output logic [SRAM_DW-1:0] rdata
);

    logic [SRAM_DW-1:0]                  mem [NUM_BINS];
    logic [$clog2(SRAM_LATENCY+1)-1:0]   busy_cnt;
    sram_op_t                            pend_op;    // op of the access in flight
    logic [SRAM_AW-1:0]                  pend_addr;
    logic                                start;

    assign start = (req.op != SRAM_NOP) && !busy;
    assign busy  = (busy_cnt != '0);

    // busy window, one per access
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy_cnt <= '0;
            pend_op  <= SRAM_NOP;
        end else if (start) begin
            busy_cnt <= $bits(busy_cnt)'(SRAM_LATENCY);
            pend_op  <= req.op;
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pend_addr <= req.addr;
        end
        if (start && req.op == SRAM_WRITE) begin
            mem[req.addr] <= req.wdata;  // write lands right away
        end
        // read data shows up as busy drops and then holds
        if (busy_cnt == 1 && pend_op == SRAM_READ) begin
            rdata <= mem[pend_addr];
        end
    end

    // requesters must wait out the busy window
    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        busy |-> req.op == SRAM_NOP
    );

    a_req_addr_known: assert property (
        @(posedge clk) disable iff (rst)
        req.op != SRAM_NOP |-> !$isunknown(req.addr)
    );

endmodule

//--- verilog/hist_pkg.sv
package hist_pkg;

    localparam logic [7:0] EOF_CODE = 8'h1A;  // end of file marker
    localparam int         NUM_BINS = 256;

    // engine states
    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        WAIT_BUSY  = 4'd1,
        READ_REQ   = 4'd2,
        READ_WAIT  = 4'd3,
        WRITE_REQ  = 4'd4,
        WRITE_WAIT = 4'd5,
        HALT       = 4'd6,
        DONE       = 4'd7
    } hist_state_t;

endpackage

//--- verilog/sram_pkg.sv
package sram_pkg;

    localparam int SRAM_AW      = 8;  // one word per byte value
    localparam int SRAM_DW      = 32;
    localparam int SRAM_LATENCY = 2;  // busy cycles after each request

    typedef enum logic [1:0] {
        SRAM_NOP   = 2'd0,
        SRAM_READ  = 2'd1,
        SRAM_WRITE = 2'd2
    } sram_op_t;

    // valid for one cycle whenever op is not SRAM_NOP
    typedef struct packed {
        sram_op_t            op;
        logic [SRAM_AW-1:0]  addr;
        logic [SRAM_DW-1:0]  wdata;
    } sram_req_t;

endpackage
